//--- rtl/rename_cfg_pkg.sv
`default_nettype none

// Register file sizes for the rename stage
package rename_cfg_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_ARCH = 32;
    localparam int NUM_PHYS = 64;

    // Physical registers not holding an architectural value after reset
    localparam int NUM_FREE = NUM_PHYS - NUM_ARCH;

    localparam int ARCH_W = $clog2(NUM_ARCH);
    localparam int PHYS_W = $clog2(NUM_PHYS);
    localparam int CNT_W  = $clog2(NUM_FREE + 1);

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PHYS_W-1:0] phys_reg_t;
    typedef logic [CNT_W-1:0]  free_cnt_t;

endpackage

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

// RV32I encodings used by the issue stage
package isa_pkg;

    // ======================================================================
    // Major opcodes
    // ======================================================================
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Class handed to dispatch
    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_LOAD,
        CLS_STORE,
        CLS_ILLEGAL
    } op_class_e;

    // ======================================================================
    // Instruction field positions
    // ======================================================================
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int REG_W      = 5;

endpackage

`default_nettype wire

//--- rtl/decode_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded fields of every lane, one packed element per lane
interface decode_lane_if #(
    parameter int ISSUE_WIDTH = 2
);

    rename_cfg_pkg::arch_reg_t [ISSUE_WIDTH-1:0] rs1;
    rename_cfg_pkg::arch_reg_t [ISSUE_WIDTH-1:0] rs2;
    rename_cfg_pkg::arch_reg_t [ISSUE_WIDTH-1:0] rd;
    logic                      [ISSUE_WIDTH-1:0] rd_we;
    isa_pkg::op_class_e        [ISSUE_WIDTH-1:0] op_class;

    modport decoder (output rs1, rs2, rd, rd_we, op_class);
    modport rename  (input rs1, rs2, rd, rd_we);
    modport pipe    (input rd, op_class);

endinterface

`default_nettype wire

//--- rtl/rv32i_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// Decodes one lane and drives that lane's slice of the shared bundle
module rv32i_decoder #(
    parameter int ISSUE_WIDTH = 2,
    parameter int LANE        = 0
) (
    input  logic [rename_cfg_pkg::XLEN-1:0] instr_i,
    decode_lane_if.decoder                  lane_o
);

    isa_pkg::opcode_e          opcode;
    isa_pkg::op_class_e        op_class;
    rename_cfg_pkg::arch_reg_t rd_field;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      writes;

    if (LANE >= ISSUE_WIDTH) begin : g_bad_lane
        $error("Decoder lane index outside the issue width");
    end

    assign opcode   = isa_pkg::opcode_e'(instr_i[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W]);
    assign rd_field = rename_cfg_pkg::arch_reg_t'(instr_i[isa_pkg::RD_LSB +: isa_pkg::REG_W]);

    always_comb begin
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        writes   = 1'b0;
        op_class = isa_pkg::CLS_ILLEGAL;
        case (opcode)
            isa_pkg::LUI, isa_pkg::AUIPC: begin
                op_class = isa_pkg::CLS_ALU;
                writes   = 1'b1;
            end
            isa_pkg::JAL: begin
                op_class = isa_pkg::CLS_JUMP;
                writes   = 1'b1;
            end
            isa_pkg::JALR: begin
                op_class = isa_pkg::CLS_JUMP;
                writes   = 1'b1;
                use_rs1  = 1'b1;
            end
            isa_pkg::BRANCH: begin
                op_class = isa_pkg::CLS_BRANCH;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            isa_pkg::LOAD: begin
                op_class = isa_pkg::CLS_LOAD;
                writes   = 1'b1;
                use_rs1  = 1'b1;
            end
            isa_pkg::STORE: begin
                op_class = isa_pkg::CLS_STORE;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            isa_pkg::OP_IMM: begin
                op_class = isa_pkg::CLS_ALU;
                writes   = 1'b1;
                use_rs1  = 1'b1;
            end
            isa_pkg::OP: begin
                op_class = isa_pkg::CLS_ALU;
                writes   = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            // Environment calls carry no register operands here
            isa_pkg::SYSTEM: op_class = isa_pkg::CLS_NONE;
            default:         op_class = isa_pkg::CLS_ILLEGAL;
        endcase
    end

    // Unused source fields read as x0 so they never alias a renamed register
    assign lane_o.rs1[LANE] = use_rs1 ?
        rename_cfg_pkg::arch_reg_t'(instr_i[isa_pkg::RS1_LSB +: isa_pkg::REG_W]) : '0;
    assign lane_o.rs2[LANE] = use_rs2 ?
        rename_cfg_pkg::arch_reg_t'(instr_i[isa_pkg::RS2_LSB +: isa_pkg::REG_W]) : '0;
    assign lane_o.rd[LANE]       = writes ? rd_field : '0;
    assign lane_o.rd_we[LANE]    = writes && (rd_field != '0);
    assign lane_o.op_class[LANE] = op_class;

endmodule

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none

// Circular buffer of free physical registers
module free_list #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [$clog2(ISSUE_WIDTH+1)-1:0]              pop_count_i,
    input  logic [ISSUE_WIDTH-1:0]                        push_valid_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]   push_phys_i,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]   head_phys_o,
    output rename_cfg_pkg::free_cnt_t                     free_count_o
);

    localparam int NUM_FREE = rename_cfg_pkg::NUM_FREE;

    typedef logic [$clog2(NUM_FREE)-1:0] ptr_t;

    rename_cfg_pkg::phys_reg_t mem [NUM_FREE];
    ptr_t                      head;
    ptr_t                      tail;
    rename_cfg_pkg::free_cnt_t count;
    ptr_t [ISSUE_WIDTH-1:0]    wr_ptr;
    int                        push_num;

    function automatic ptr_t next_ptr(ptr_t p, int k);
        return ptr_t'((int'(p) + k) % NUM_FREE);
    endfunction

    // Pushes land at the tail in lane order, skipping idle lanes
    always_comb begin
        push_num = 0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            wr_ptr[w] = next_ptr(tail, push_num);
            if (push_valid_i[w]) begin
                push_num = push_num + 1;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            head_phys_o[w] = mem[next_ptr(head, w)];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Buffer starts full with the registers above the architectural ones
            for (int i = 0; i < NUM_FREE; i++) begin
                mem[i] <= rename_cfg_pkg::phys_reg_t'(rename_cfg_pkg::NUM_ARCH + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= rename_cfg_pkg::free_cnt_t'(NUM_FREE);
        end else begin
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (push_valid_i[w]) begin
                    mem[wr_ptr[w]] <= push_phys_i[w];
                end
            end
            head  <= next_ptr(head, int'(pop_count_i));
            tail  <= next_ptr(tail, push_num);
            count <= rename_cfg_pkg::free_cnt_t'(int'(count) - int'(pop_count_i) + push_num);
        end
    end

    assign free_count_o = count;

endmodule

`default_nettype wire

//--- rtl/register_alias_table.sv
`timescale 1ns/1ps
`default_nettype none

// Map table, group renaming and destination allocation
module register_alias_table #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        flush_i,
    input  logic                                        bubble_i,
    input  logic [ISSUE_WIDTH-1:0]                      decode_valid_i,
    input  logic [ISSUE_WIDTH-1:0]                      dispatch_ready_i,
    input  logic [ISSUE_WIDTH-1:0]                      commit_valid_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] commit_phys_i,
    decode_lane_if.rename                               dec_i,
    output logic [ISSUE_WIDTH-1:0]                      decode_ready_o,
    output logic [ISSUE_WIDTH-1:0]                      accept_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rs1_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rs2_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rd_phys_o
);

    typedef logic [$clog2(ISSUE_WIDTH+1)-1:0] cnt_t;

    rename_cfg_pkg::phys_reg_t                   map_q [rename_cfg_pkg::NUM_ARCH];
    rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] head_phys;
    rename_cfg_pkg::free_cnt_t                   free_count;
    cnt_t                                        pop_count;
    logic                                        room;
    logic [ISSUE_WIDTH-1:0]                      alloc;

    // ======================================================================
    // Acceptance
    // ======================================================================
    // A full group must always fit, so readiness never depends on the lanes
    assign room           = free_count >= rename_cfg_pkg::free_cnt_t'(ISSUE_WIDTH);
    assign decode_ready_o = dispatch_ready_i & {ISSUE_WIDTH{room && !flush_i && !bubble_i}};
    assign accept_o       = decode_valid_i & decode_ready_o;
    assign alloc          = accept_o & dec_i.rd_we;

    // ======================================================================
    // Renaming
    // ======================================================================
    always_comb begin
        pop_count = '0;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            rs1_phys_o[w] = map_q[dec_i.rs1[w]];
            rs2_phys_o[w] = map_q[dec_i.rs2[w]];
            // Latest earlier writer in the group overrides the table
            for (int p = 0; p < w; p++) begin
                if (alloc[p] && (dec_i.rd[p] == dec_i.rs1[w])) begin
                    rs1_phys_o[w] = rd_phys_o[p];
                end
                if (alloc[p] && (dec_i.rd[p] == dec_i.rs2[w])) begin
                    rs2_phys_o[w] = rd_phys_o[p];
                end
            end
            rd_phys_o[w] = '0;
            if (alloc[w]) begin
                rd_phys_o[w] = head_phys[pop_count];
                pop_count    = pop_count + cnt_t'(1);
            end
        end
    end

    // Later lanes are assigned last, so they win on a shared rd
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rename_cfg_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_cfg_pkg::phys_reg_t'(i);
            end
        end else begin
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (alloc[w]) begin
                    map_q[dec_i.rd[w]] <= rd_phys_o[w];
                end
            end
        end
    end

    free_list #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_free_list (
        .clk          (clk),
        .reset        (reset),
        .pop_count_i  (pop_count),
        .push_valid_i (commit_valid_i),
        .push_phys_i  (commit_phys_i),
        .head_phys_o  (head_phys),
        .free_count_o (free_count)
    );

endmodule

`default_nettype wire

//--- rtl/issue_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One register stage per lane toward dispatch
module issue_pipe_reg #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [ISSUE_WIDTH-1:0]                         dispatch_ready_i,
    input  logic [ISSUE_WIDTH-1:0]                         accept_i,
    input  logic [ISSUE_WIDTH-1:0][rename_cfg_pkg::XLEN-1:0] pc_i,
    decode_lane_if.pipe                                    dec_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs1_phys_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs2_phys_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rd_phys_i,
    output logic [ISSUE_WIDTH-1:0]                         dispatch_valid_o,
    output isa_pkg::op_class_e [ISSUE_WIDTH-1:0]           op_class_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs1_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs2_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rd_phys_o,
    output rename_cfg_pkg::arch_reg_t [ISSUE_WIDTH-1:0]    rd_arch_o,
    output logic [ISSUE_WIDTH-1:0][rename_cfg_pkg::XLEN-1:0] pc_o
);

    // Valid drops on a stalled lane while its fields hold
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dispatch_valid_o <= '0;
        end else begin
            dispatch_valid_o <= dispatch_ready_i & accept_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            if (dispatch_ready_i[w]) begin
                op_class_o[w] <= dec_i.op_class[w];
                rs1_phys_o[w] <= rs1_phys_i[w];
                rs2_phys_o[w] <= rs2_phys_i[w];
                rd_phys_o[w]  <= rd_phys_i[w];
                rd_arch_o[w]  <= dec_i.rd[w];
                pc_o[w]       <= pc_i[w];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Issue stage top level with decode, rename and the register toward dispatch
module issue_stage #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           flush_i,
    input  logic                                           bubble_i,
    input  logic [ISSUE_WIDTH-1:0]                         decode_valid_i,
    input  logic [ISSUE_WIDTH-1:0][rename_cfg_pkg::XLEN-1:0] instr_i,
    input  logic [ISSUE_WIDTH-1:0][rename_cfg_pkg::XLEN-1:0] pc_i,
    input  logic [ISSUE_WIDTH-1:0]                         dispatch_ready_i,
    input  logic [ISSUE_WIDTH-1:0]                         commit_valid_i,
    input  rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    commit_phys_i,
    output logic [ISSUE_WIDTH-1:0]                         decode_ready_o,
    output logic [ISSUE_WIDTH-1:0]                         dispatch_valid_o,
    output isa_pkg::op_class_e [ISSUE_WIDTH-1:0]           op_class_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs1_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rs2_phys_o,
    output rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0]    rd_phys_o,
    output rename_cfg_pkg::arch_reg_t [ISSUE_WIDTH-1:0]    rd_arch_o,
    output logic [ISSUE_WIDTH-1:0][rename_cfg_pkg::XLEN-1:0] pc_o
);

    logic [ISSUE_WIDTH-1:0]                      accept;
    rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rs1_phys;
    rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rs2_phys;
    rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rd_phys;

    decode_lane_if #(.ISSUE_WIDTH(ISSUE_WIDTH)) dec_if ();

    for (genvar w = 0; w < ISSUE_WIDTH; w++) begin : g_dec
        rv32i_decoder #(
            .ISSUE_WIDTH (ISSUE_WIDTH),
            .LANE        (w)
        ) u_decoder (
            .instr_i (instr_i[w]),
            .lane_o  (dec_if.decoder)
        );
    end

    register_alias_table #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_rat (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .decode_valid_i   (decode_valid_i),
        .dispatch_ready_i (dispatch_ready_i),
        .commit_valid_i   (commit_valid_i),
        .commit_phys_i    (commit_phys_i),
        .dec_i            (dec_if.rename),
        .decode_ready_o   (decode_ready_o),
        .accept_o         (accept),
        .rs1_phys_o       (rs1_phys),
        .rs2_phys_o       (rs2_phys),
        .rd_phys_o        (rd_phys)
    );

    issue_pipe_reg #(
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_pipe_reg (
        .clk              (clk),
        .reset            (reset),
        .dispatch_ready_i (dispatch_ready_i),
        .accept_i         (accept),
        .pc_i             (pc_i),
        .dec_i            (dec_if.pipe),
        .rs1_phys_i       (rs1_phys),
        .rs2_phys_i       (rs2_phys),
        .rd_phys_i        (rd_phys),
        .dispatch_valid_o (dispatch_valid_o),
        .op_class_o       (op_class_o),
        .rs1_phys_o       (rs1_phys_o),
        .rs2_phys_o       (rs2_phys_o),
        .rd_phys_o        (rd_phys_o),
        .rd_arch_o        (rd_arch_o),
        .pc_o             (pc_o)
    );

endmodule

`default_nettype wire

//--- tb/issue_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake and allocation properties of the issue stage
module issue_stage_chk #(
    parameter int ISSUE_WIDTH = 2
) (
    input logic                                        clk,
    input logic                                        reset,
    input logic                                        flush_i,
    input logic                                        bubble_i,
    input logic [ISSUE_WIDTH-1:0]                      decode_valid_i,
    input logic [ISSUE_WIDTH-1:0]                      decode_ready_o,
    input logic [ISSUE_WIDTH-1:0]                      dispatch_valid_o,
    input rename_cfg_pkg::phys_reg_t [ISSUE_WIDTH-1:0] rd_phys_o
);

    for (genvar w = 0; w < ISSUE_WIDTH; w++) begin : g_lane
        // A lane leaves only what was accepted one cycle before
        a_valid_after_accept: assert property (@(posedge clk) disable iff (!reset)
            dispatch_valid_o[w] |-> $past(decode_valid_i[w] && decode_ready_o[w]))
            else $error("dispatch_valid_o[%0d] without acceptance", w);

        for (genvar q = w + 1; q < ISSUE_WIDTH; q++) begin : g_pair
            a_unique_dest: assert property (@(posedge clk) disable iff (!reset)
                (dispatch_valid_o[w] && dispatch_valid_o[q] && (rd_phys_o[w] != '0))
                |-> (rd_phys_o[w] != rd_phys_o[q]))
                else $error("Lanes %0d and %0d share rd_phys_o", w, q);
        end
    end

    a_stall_blocks_ready: assert property (@(posedge clk) disable iff (!reset)
        (flush_i || bubble_i) |-> (decode_ready_o == '0))
        else $error("decode_ready_o high during flush or bubble");

endmodule

bind issue_stage issue_stage_chk #(
    .ISSUE_WIDTH (ISSUE_WIDTH)
) u_chk (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush_i),
    .bubble_i         (bubble_i),
    .decode_valid_i   (decode_valid_i),
    .decode_ready_o   (decode_ready_o),
    .dispatch_valid_o (dispatch_valid_o),
    .rd_phys_o        (rd_phys_o)
);

`default_nettype wire

//--- tb/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;

    localparam int W = 2;
    // Reset 4, directed tests 26, random stream 150, drain 1
    localparam int TEST_CYCLES = 181;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
    localparam logic [6:0] OP_TAB [11] = '{isa_pkg::LUI, isa_pkg::AUIPC, isa_pkg::JAL,
        isa_pkg::JALR, isa_pkg::BRANCH, isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::OP_IMM,
        isa_pkg::OP, isa_pkg::SYSTEM, 7'h7f};

    logic                                clk = 1'b0;
    logic                                reset;
    logic                                flush_i;
    logic                                bubble_i;
    logic [W-1:0]                        decode_valid_i;
    logic [W-1:0][31:0]                  instr_i;
    logic [W-1:0][31:0]                  pc_i;
    logic [W-1:0]                        dispatch_ready_i;
    logic [W-1:0]                        commit_valid_i;
    rename_cfg_pkg::phys_reg_t [W-1:0]   commit_phys_i;
    logic [W-1:0]                        decode_ready_o;
    logic [W-1:0]                        dispatch_valid_o;
    isa_pkg::op_class_e [W-1:0]          op_class_o;
    rename_cfg_pkg::phys_reg_t [W-1:0]   rs1_phys_o;
    rename_cfg_pkg::phys_reg_t [W-1:0]   rs2_phys_o;
    rename_cfg_pkg::phys_reg_t [W-1:0]   rd_phys_o;
    rename_cfg_pkg::arch_reg_t [W-1:0]   rd_arch_o;
    logic [W-1:0][31:0]                  pc_o;

    // Reference model state
    int                                  map_m [32];
    int                                  free_q [$];
    int                                  inflight [$];
    logic [W-1:0]                        exp_valid = '0;
    logic [W-1:0]                        loaded = '0;
    logic [31:0]                         exp_cls [W];
    logic [31:0]                         exp_rs1 [W];
    logic [31:0]                         exp_rs2 [W];
    logic [31:0]                         exp_rd [W];
    logic [31:0]                         exp_arch [W];
    logic [31:0]                         exp_pc [W];
    logic [W-1:0]                        cv_next = '0;
    rename_cfg_pkg::phys_reg_t [W-1:0]   cp_next;
    logic [31:0]                         pc_next = 32'h1000;
    logic [31:0]                         lfsr = 32'hc454_5d5a;
    int                                  checks = 0;
    int                                  errors = 0;
    int                                  cycles = 0;

    issue_stage #(.ISSUE_WIDTH(W)) issue_stage_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic int rand_bits(int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc(logic [6:0] op, int rd, int rs1, int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'(rd), op};
    endfunction

    // {writes rd, reads rs1, reads rs2, class}
    function automatic logic [5:0] op_info(logic [6:0] op);
        case (op)
            isa_pkg::LUI, isa_pkg::AUIPC: return {3'b100, isa_pkg::CLS_ALU};
            isa_pkg::JAL:    return {3'b100, isa_pkg::CLS_JUMP};
            isa_pkg::JALR:   return {3'b110, isa_pkg::CLS_JUMP};
            isa_pkg::BRANCH: return {3'b011, isa_pkg::CLS_BRANCH};
            isa_pkg::LOAD:   return {3'b110, isa_pkg::CLS_LOAD};
            isa_pkg::STORE:  return {3'b011, isa_pkg::CLS_STORE};
            isa_pkg::OP_IMM: return {3'b110, isa_pkg::CLS_ALU};
            isa_pkg::OP:     return {3'b111, isa_pkg::CLS_ALU};
            isa_pkg::SYSTEM: return {3'b000, isa_pkg::CLS_NONE};
            default:         return {3'b000, isa_pkg::CLS_ILLEGAL};
        endcase
    endfunction

    task automatic check_val(string name, int w, logic [31:0] exp, logic [31:0] got);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at %0t: %s[%0d] expected %0h, got %0h", $time, name, w, exp, got);
        end
    endtask

    task automatic check_outputs();
        for (int w = 0; w < W; w++) begin
            check_val("dispatch_valid_o", w, exp_valid[w], dispatch_valid_o[w]);
            if (loaded[w]) begin
                check_val("op_class_o", w, exp_cls[w], op_class_o[w]);
                check_val("rs1_phys_o", w, exp_rs1[w], rs1_phys_o[w]);
                check_val("rs2_phys_o", w, exp_rs2[w], rs2_phys_o[w]);
                check_val("rd_phys_o", w, exp_rd[w], rd_phys_o[w]);
                check_val("rd_arch_o", w, exp_arch[w], rd_arch_o[w]);
                check_val("pc_o", w, exp_pc[w], pc_o[w]);
            end
        end
    endtask

    // Check the last group, drive the next one and step the model
    task automatic step(input logic [31:0] i0, input logic [31:0] i1, input logic [W-1:0] v,
                        input logic [W-1:0] r, input logic fl, input logic bb);
        logic [W-1:0] acc;
        logic [W-1:0] we_l;
        logic [5:0]   info;
        logic         open;
        int           rd_l [W];
        int           new_rd [W];
        int           a1;
        int           a2;
        int           p1;
        int           p2;
        @(negedge clk);
        check_outputs();
        instr_i          = {i1, i0};
        decode_valid_i   = v;
        dispatch_ready_i = r;
        flush_i          = fl;
        bubble_i         = bb;
        commit_valid_i   = cv_next;
        commit_phys_i    = cp_next;
        for (int w = 0; w < W; w++) begin
            pc_i[w] = pc_next + 32'(4 * w);
        end
        pc_next = pc_next + 32'(4 * W);
        #1;
        open = (free_q.size() >= W) && !fl && !bb;
        for (int w = 0; w < W; w++) begin
            acc[w] = v[w] && r[w] && open;
            check_val("decode_ready_o", w, r[w] && open, decode_ready_o[w]);
            info    = op_info(instr_i[w][6:0]);
            rd_l[w] = info[5] ? int'(instr_i[w][11:7]) : 0;
            we_l[w] = info[5] && (rd_l[w] != 0);
            a1 = info[4] ? int'(instr_i[w][19:15]) : 0;
            a2 = info[3] ? int'(instr_i[w][24:20]) : 0;
            p1 = map_m[a1];
            p2 = map_m[a2];
            for (int p = 0; p < w; p++) begin
                if (acc[p] && we_l[p] && (rd_l[p] == a1)) begin
                    p1 = new_rd[p];
                end
                if (acc[p] && we_l[p] && (rd_l[p] == a2)) begin
                    p2 = new_rd[p];
                end
            end
            new_rd[w] = 0;
            if (acc[w] && we_l[w]) begin
                new_rd[w] = free_q.pop_front();
                inflight.push_back(new_rd[w]);
            end
            exp_valid[w] = acc[w];
            if (r[w]) begin
                loaded[w]   = 1'b1;
                exp_cls[w]  = 32'(info[2:0]);
                exp_rs1[w]  = p1;
                exp_rs2[w]  = p2;
                exp_rd[w]   = new_rd[w];
                exp_arch[w] = rd_l[w];
                exp_pc[w]   = pc_i[w];
            end
        end
        for (int w = 0; w < W; w++) begin
            if (acc[w] && we_l[w]) begin
                map_m[rd_l[w]] = new_rd[w];
            end
        end
        // Commits reach the tail at this edge, after the pops
        for (int w = 0; w < W; w++) begin
            if (cv_next[w]) begin
                free_q.push_back(int'(cp_next[w]));
            end
        end
        cv_next = '0;
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic first_group();
        step(enc(isa_pkg::OP, 5, 1, 2), enc(isa_pkg::OP, 6, 3, 4), '1, '1, 1'b0, 1'b0);
    endtask

    task automatic decode_classes();
        step(enc(isa_pkg::LOAD, 7, 5, 9), enc(isa_pkg::STORE, 3, 6, 7), '1, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::BRANCH, 4, 5, 6), enc(isa_pkg::JAL, 8, 9, 10), '1, '1, 1'b0, 1'b0);
        step(enc(7'h7f, 9, 1, 2), enc(isa_pkg::OP, 0, 1, 2), '1, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::SYSTEM, 3, 3, 3), enc(isa_pkg::LUI, 9, 31, 31), '1, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::JALR, 14, 7, 30), enc(isa_pkg::AUIPC, 15, 14, 3), '1, '1, 1'b0, 1'b0);
    endtask

    task automatic group_dependency();
        step(enc(isa_pkg::OP, 10, 1, 2), enc(isa_pkg::OP, 11, 10, 10), '1, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::OP, 12, 10, 11), enc(isa_pkg::OP, 12, 12, 3), '1, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::OP_IMM, 13, 12, 0), enc(isa_pkg::OP, 14, 12, 11), '1, '1, 1'b0, 1'b0);
    endtask

    task automatic stalls_and_flush();
        step(enc(isa_pkg::OP, 16, 1, 2), enc(isa_pkg::OP, 17, 16, 2), '1, 2'b10, 1'b0, 1'b0);
        step(enc(isa_pkg::OP, 18, 17, 2), enc(isa_pkg::OP, 19, 18, 2), '1, 2'b01, 1'b0, 1'b0);
        step(enc(isa_pkg::OP, 20, 19, 2), enc(isa_pkg::OP, 21, 1, 2), '1, '1, 1'b1, 1'b0);
        step(enc(isa_pkg::OP, 20, 19, 2), enc(isa_pkg::OP, 21, 1, 2), '1, '1, 1'b0, 1'b1);
        step(enc(isa_pkg::OP, 20, 19, 2), enc(isa_pkg::OP, 21, 20, 2), 2'b01, '1, 1'b0, 1'b0);
        step(enc(isa_pkg::OP, 22, 21, 20), enc(isa_pkg::OP, 23, 22, 21), '1, '1, 1'b0, 1'b0);
    endtask

    task automatic exhaustion_and_commit();
        int a;
        int b;
        while (free_q.size() >= W) begin
            step(enc(isa_pkg::OP, 24, 24, 1), enc(isa_pkg::OP, 25, 24, 25), '1, '1, 1'b0, 1'b0);
        end
        step(enc(isa_pkg::OP, 26, 1, 2), enc(isa_pkg::OP, 27, 3, 4), '1, '1, 1'b0, 1'b0);
        for (int k = 0; k < 2; k++) begin
            a = inflight.pop_front();
            b = inflight.pop_front();
            // Lane 1 commits the older register
            cv_next = '1;
            cp_next = {6'(a), 6'(b)};
            step(enc(isa_pkg::OP, 26, 1, 2), enc(isa_pkg::OP, 27, 26, 4), '1, '1, 1'b0, 1'b0);
        end
        step(enc(isa_pkg::OP, 28, 26, 27), enc(isa_pkg::OP, 29, 28, 4), '1, '1, 1'b0, 1'b0);
    endtask

    task automatic random_stream(int n);
        int idx;
        for (int i = 0; i < n; i++) begin
            for (int w = 0; w < W; w++) begin
                cv_next[w] = (inflight.size() > 0) && (rand_bits(1) == 1);
                if (cv_next[w]) begin
                    idx        = rand_bits(6) % inflight.size();
                    cp_next[w] = 6'(inflight[idx]);
                    inflight.delete(idx);
                end
            end
            step(enc(OP_TAB[rand_bits(4) % 11], rand_bits(5), rand_bits(5), rand_bits(5)),
                 enc(OP_TAB[rand_bits(4) % 11], rand_bits(5), rand_bits(5), rand_bits(5)),
                 2'(rand_bits(2)), {rand_bits(2) != 0, rand_bits(2) != 0},
                 rand_bits(4) == 0, rand_bits(4) == 0);
        end
    endtask

    initial begin
        reset            = 1'b0;
        flush_i          = 1'b0;
        bubble_i         = 1'b0;
        decode_valid_i   = '0;
        instr_i          = '0;
        pc_i             = '0;
        dispatch_ready_i = '1;
        commit_valid_i   = '0;
        commit_phys_i    = '0;
        cp_next          = '0;
        for (int i = 0; i < 32; i++) begin
            map_m[i] = i;
            free_q.push_back(32 + i);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        first_group();
        decode_classes();
        group_dependency();
        stalls_and_flush();
        exhaustion_and_commit();
        random_stream(150);
        step('0, '0, '0, '1, 1'b0, 1'b0);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rename_issue.f
rtl/rename_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/decode_lane_if.sv
rtl/rv32i_decoder.sv
rtl/free_list.sv
rtl/register_alias_table.sv
rtl/issue_pipe_reg.sv
rtl/issue_stage.sv
tb/issue_stage_chk.sv
tb/tb_issue_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_stage \
    -f rename_issue.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Regression failed" >> sim.log
cat sim.log
if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
